// File: hdl/mister_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MiSTer control package
// Widths, OSD status bit positions and the
// shared types of the player input path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mister_pkg;

    // Bus and word widths
    localparam int STATUS_W   = 64;
    localparam int WB_DW      = 32;
    localparam int JOY_W      = 16;
    localparam int GAME_JOY_W = 10;
    localparam int PLAYERS    = 4;

    // Decoded field widths
    localparam int OFFSET_W   = 4;
    localparam int SCALE_W    = 4;
    localparam int MENUMASK_W = 16;
    localparam int CORE_MOD_W = 7;

    // Field positions inside the OSD status word
    localparam int HSIZE_EN_BIT    = 19;
    localparam int HSIZE_SCALE_LSB = 20;
    localparam int HOFF_LSB        = 24;
    localparam int VOFF_LSB        = 28;
    localparam int DB15_1_BIT      = 61;
    localparam int DB15_2_BIT      = 62;

    // Bits of a raw DB15 word used by the remap
    localparam int DB15_SEL_BIT   = 5;
    localparam int DB15_START_BIT = 10;
    localparam int DB15_COIN_BIT  = 11;

    typedef logic [STATUS_W-1:0]   status_t;
    typedef logic [WB_DW-1:0]      wb_data_t;
    typedef logic [JOY_W-1:0]      joy_word_t;
    typedef logic [GAME_JOY_W-1:0] game_joy_t;
    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [MENUMASK_W-1:0] menumask_t;

endpackage

`default_nettype wire

// File: hdl/osd_status.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OSD status register
// Wishbone slave for the two status halves
// and decode of the video and DB15 fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module osd_status
    import mister_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  rst,

    // Host port
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic                  wb_adr,
    input  wb_data_t              wb_dat_w,
    output wb_data_t              wb_dat_r,
    output logic                  wb_ack,

    // Core configuration
    input  logic [CORE_MOD_W-1:0] core_mod,
    input  logic                  direct_video,

    // Decoded status
    output status_t               status,
    output offset_t               hoffset,
    output offset_t               voffset,
    output logic                  hsize_enable,
    output logic [SCALE_W-1:0]    hsize_scale,
    output menumask_t             status_menumask,
    output logic                  db15_1_en,
    output logic                  db15_2_en
);

    logic access;

    // New access only when ack was low in the previous cycle
    assign access = wb_cyc & wb_stb & ~wb_ack;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // Write lands together with the rising ack
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            status <= '0;
        end else if (access && wb_we) begin
            if (wb_adr) begin
                status[STATUS_W-1:WB_DW] <= wb_dat_w;
            end else begin
                status[WB_DW-1:0] <= wb_dat_w;
            end
        end
    end

    // Read data valid while ack is high
    always_ff @(posedge clk_sys) begin
        if (access) begin
            wb_dat_r <= wb_adr ? status[STATUS_W-1:WB_DW] : status[WB_DW-1:0];
        end
    end

    // Video offsets and horizontal scaler
    assign hoffset      = status[HOFF_LSB +: OFFSET_W];
    assign voffset      = status[VOFF_LSB +: OFFSET_W];
    assign hsize_enable = status[HSIZE_EN_BIT];
    assign hsize_scale  = status[HSIZE_SCALE_LSB +: SCALE_W];

    // Menu entries hidden by the OSD
    always_comb begin
        status_menumask    = '0;
        status_menumask[2] = ~hsize_enable;
        status_menumask[1] = ~core_mod[0];
        status_menumask[0] = direct_video;
    end

    // DB15 port enables
    assign db15_1_en = status[DB15_1_BIT];
    assign db15_2_en = status[DB15_2_BIT];

endmodule

`default_nettype wire

// File: hdl/joy_source_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Joystick source selection
// Remaps DB15 words and shifts USB slots
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module joy_source_mux
    import mister_pkg::*;
#(
    parameter int BUTTONS = 2
)(
    input  logic      clk_sys,
    input  logic      rst,

    input  logic      db15_1_en,
    input  logic      db15_2_en,

    input  joy_word_t joydb_1,
    input  joy_word_t joydb_2,
    input  joy_word_t usb_joy1,
    input  joy_word_t usb_joy2,
    input  joy_word_t usb_joy3,
    input  joy_word_t usb_joy4,

    output joy_word_t sel_joy1,
    output joy_word_t sel_joy2,
    output joy_word_t sel_joy3,
    output joy_word_t sel_joy4
);

    joy_word_t db15_1_map;
    joy_word_t db15_2_map;
    joy_word_t nxt_joy1;
    joy_word_t nxt_joy2;
    joy_word_t nxt_joy3;
    joy_word_t nxt_joy4;

    // Start and coin move just above the buttons
    function automatic joy_word_t remap_db15(input joy_word_t raw);
        joy_word_t res;
        res = '0;
        res[BUTTONS+3:0] = raw[BUTTONS+3:0];
        res[BUTTONS+4]   = raw[DB15_START_BIT];
        // Coin also from start plus select
        res[BUTTONS+5]   = raw[DB15_COIN_BIT] |
                           (raw[DB15_START_BIT] & raw[DB15_SEL_BIT]);
        return res;
    endfunction

    assign db15_1_map = remap_db15(joydb_1);
    assign db15_2_map = remap_db15(joydb_2);

    // USB slots slide down behind active DB15 ports
    always_comb begin
        nxt_joy1 = db15_1_en ? db15_1_map : usb_joy1;
        nxt_joy2 = db15_2_en ? db15_2_map : (db15_1_en ? usb_joy1 : usb_joy2);
        nxt_joy3 = db15_1_en ? usb_joy1 : (db15_2_en ? usb_joy2 : usb_joy3);
        nxt_joy4 = db15_1_en ? usb_joy2 : (db15_2_en ? usb_joy3 : usb_joy4);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            sel_joy1 <= '0;
            sel_joy2 <= '0;
            sel_joy3 <= '0;
            sel_joy4 <= '0;
        end else begin
            sel_joy1 <= nxt_joy1;
            sel_joy2 <= nxt_joy2;
            sel_joy3 <= nxt_joy3;
            sel_joy4 <= nxt_joy4;
        end
    end

endmodule

`default_nettype wire

// File: hdl/game_input_map.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game input formatting
// Joystick, start and coin per player
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module game_input_map
    import mister_pkg::*;
#(
    parameter int BUTTONS                = 2,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
)(
    input  logic               clk_sys,
    input  logic               rst,

    input  joy_word_t          sel_joy1,
    input  joy_word_t          sel_joy2,
    input  joy_word_t          sel_joy3,
    input  joy_word_t          sel_joy4,

    output game_joy_t          game_joystick1,
    output game_joy_t          game_joystick2,
    output game_joy_t          game_joystick3,
    output game_joy_t          game_joystick4,
    output logic [PLAYERS-1:0] game_start,
    output logic [PLAYERS-1:0] game_coin
);

    // Polarity applied to every output bit
    localparam logic POL = GAME_INPUTS_ACTIVE_LOW;

    joy_word_t sel  [PLAYERS];
    game_joy_t joy_q[PLAYERS];

    assign sel[0] = sel_joy1;
    assign sel[1] = sel_joy2;
    assign sel[2] = sel_joy3;
    assign sel[3] = sel_joy4;

    // Directions and buttons only
    function automatic game_joy_t fmt_joy(input joy_word_t word);
        game_joy_t res;
        res = '0;
        res[BUTTONS+3:0] = word[BUTTONS+3:0];
        return res;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int n = 0; n < PLAYERS; n++) begin
                joy_q[n] <= {GAME_JOY_W{POL}};
            end
            game_start <= {PLAYERS{POL}};
            game_coin  <= {PLAYERS{POL}};
        end else begin
            for (int n = 0; n < PLAYERS; n++) begin
                joy_q[n]      <= fmt_joy(sel[n]) ^ {GAME_JOY_W{POL}};
                game_start[n] <= sel[n][BUTTONS+4] ^ POL;
                game_coin[n]  <= sel[n][BUTTONS+5] ^ POL;
            end
        end
    end

    assign game_joystick1 = joy_q[0];
    assign game_joystick2 = joy_q[1];
    assign game_joystick3 = joy_q[2];
    assign game_joystick4 = joy_q[3];

endmodule

`default_nettype wire

// File: hdl/mister_ctrl_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MiSTer control top level
// OSD status decode, joystick source mux
// and game input formatting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module mister_ctrl_top
    import mister_pkg::*;
#(
    parameter int BUTTONS                = 2,
    parameter bit GAME_INPUTS_ACTIVE_LOW = 1'b1
)(
    input  logic                  clk_sys,
    input  logic                  rst,

    // Host status port
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic                  wb_adr,
    input  wb_data_t              wb_dat_w,
    output wb_data_t              wb_dat_r,
    output logic                  wb_ack,

    input  logic [CORE_MOD_W-1:0] core_mod,
    input  logic                  direct_video,

    // Raw joystick sources
    input  joy_word_t             joydb_1,
    input  joy_word_t             joydb_2,
    input  joy_word_t             usb_joy1,
    input  joy_word_t             usb_joy2,
    input  joy_word_t             usb_joy3,
    input  joy_word_t             usb_joy4,

    // OSD settings
    output status_t               status,
    output offset_t               hoffset,
    output offset_t               voffset,
    output logic                  hsize_enable,
    output logic [SCALE_W-1:0]    hsize_scale,
    output menumask_t             status_menumask,

    // Game side
    output game_joy_t             game_joystick1,
    output game_joy_t             game_joystick2,
    output game_joy_t             game_joystick3,
    output game_joy_t             game_joystick4,
    output logic [PLAYERS-1:0]    game_start,
    output logic [PLAYERS-1:0]    game_coin
);

    logic      db15_1_en;
    logic      db15_2_en;
    joy_word_t sel_joy1;
    joy_word_t sel_joy2;
    joy_word_t sel_joy3;
    joy_word_t sel_joy4;

    osd_status u_status (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .wb_cyc          ( wb_cyc          ),
        .wb_stb          ( wb_stb          ),
        .wb_we           ( wb_we           ),
        .wb_adr          ( wb_adr          ),
        .wb_dat_w        ( wb_dat_w        ),
        .wb_dat_r        ( wb_dat_r        ),
        .wb_ack          ( wb_ack          ),
        .core_mod        ( core_mod        ),
        .direct_video    ( direct_video    ),
        .status          ( status          ),
        .hoffset         ( hoffset         ),
        .voffset         ( voffset         ),
        .hsize_enable    ( hsize_enable    ),
        .hsize_scale     ( hsize_scale     ),
        .status_menumask ( status_menumask ),
        .db15_1_en       ( db15_1_en       ),
        .db15_2_en       ( db15_2_en       )
    );

    joy_source_mux #(
        .BUTTONS   ( BUTTONS   )
    ) u_joymux (
        .clk_sys   ( clk_sys   ),
        .rst       ( rst       ),
        .db15_1_en ( db15_1_en ),
        .db15_2_en ( db15_2_en ),
        .joydb_1   ( joydb_1   ),
        .joydb_2   ( joydb_2   ),
        .usb_joy1  ( usb_joy1  ),
        .usb_joy2  ( usb_joy2  ),
        .usb_joy3  ( usb_joy3  ),
        .usb_joy4  ( usb_joy4  ),
        .sel_joy1  ( sel_joy1  ),
        .sel_joy2  ( sel_joy2  ),
        .sel_joy3  ( sel_joy3  ),
        .sel_joy4  ( sel_joy4  )
    );

    game_input_map #(
        .BUTTONS                ( BUTTONS                ),
        .GAME_INPUTS_ACTIVE_LOW ( GAME_INPUTS_ACTIVE_LOW )
    ) u_game (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .sel_joy1       ( sel_joy1       ),
        .sel_joy2       ( sel_joy2       ),
        .sel_joy3       ( sel_joy3       ),
        .sel_joy4       ( sel_joy4       ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_joystick3 ( game_joystick3 ),
        .game_joystick4 ( game_joystick4 ),
        .game_start     ( game_start     ),
        .game_coin      ( game_coin      )
    );

endmodule

`default_nettype wire

// File: tests/tb_mister_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MiSTer control testbench
// Directed tests of the OSD status port
// and of the player input path
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module tb_mister_ctrl
    import mister_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BUTTONS     = 2;
    localparam bit ACTIVE_LOW  = 1'b1;
    localparam int ACK_TIMEOUT = 20;

    logic clk_sys, rst, wb_cyc, wb_stb, wb_we, wb_adr, wb_ack, direct_video, hsize_enable;
    wb_data_t wb_dat_w, wb_dat_r;
    logic [CORE_MOD_W-1:0] core_mod;
    joy_word_t joydb_1, joydb_2, usb_joy1, usb_joy2, usb_joy3, usb_joy4;
    status_t status;
    offset_t hoffset, voffset;
    logic [SCALE_W-1:0] hsize_scale;
    menumask_t status_menumask;
    game_joy_t game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic [PLAYERS-1:0] game_start, game_coin;
    int errors, checks, timeouts;

    mister_ctrl_top dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic report(input string msg);
        errors++;
        $display("[FAIL] t=%0d ns: %s", $time, msg);
    endtask

    task automatic check_status(input status_t got, input status_t exp, input string what);
        checks++;
        if (got !== exp) report($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_offset(input offset_t got, input offset_t exp, input string what);
        checks++;
        if (got !== exp) report($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_menumask(input menumask_t got, input menumask_t exp, input string what);
        checks++;
        if (got !== exp) report($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_game_joy(input game_joy_t got, input game_joy_t exp, input string what);
        checks++;
        if (got !== exp) report($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic check_bits(input logic [3:0] got, input logic [3:0] exp, input string what);
        checks++;
        if (got !== exp) report($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // One classic cycle from falling edge to falling edge
    task automatic wb_access(input logic we, input logic adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int n;
        n = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk_sys);
        while (!wb_ack && n < ACK_TIMEOUT) begin
            @(negedge clk_sys);
            n++;
        end
        if (!wb_ack) begin
            $display("Timeout: no Wishbone ack within %0d cycles", ACK_TIMEOUT);
            timeouts++;
            finish_run();
        end else begin
            if (n != 0) report($sformatf("ack came %0d cycles late", n));
            rdata  = wb_dat_r;
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
            @(negedge clk_sys);
            check_bits({3'b0, wb_ack}, 4'b0, "ack after one pulse");
        end
    endtask

    // Expected game joystick from one selected word
    function automatic game_joy_t expect_joy(input joy_word_t w);
        game_joy_t g;
        g = '0;
        for (int b = 0; b < BUTTONS + 4; b++) g[b] = w[b];
        return ACTIVE_LOW ? ~g : g;
    endfunction

    // DB15 word with start and coin moved above the buttons
    function automatic joy_word_t expect_db15(input joy_word_t raw);
        joy_word_t w;
        w = raw & joy_word_t'((1 << (BUTTONS + 4)) - 1);
        w[BUTTONS+4] = raw[10];
        w[BUTTONS+5] = raw[11] | (raw[10] & raw[5]);
        return w;
    endfunction

    task automatic predict(input logic en1, input logic en2, input joy_word_t db[2],
                           input joy_word_t usb[PLAYERS], output joy_word_t exp[PLAYERS]);
        exp[0] = en1 ? expect_db15(db[0]) : usb[0];
        exp[1] = en2 ? expect_db15(db[1]) : (en1 ? usb[0] : usb[1]);
        exp[2] = en1 ? usb[0] : (en2 ? usb[1] : usb[2]);
        exp[3] = en1 ? usb[1] : (en2 ? usb[2] : usb[3]);
    endtask

    task automatic compare_players(input joy_word_t exp[PLAYERS], input int idx);
        logic [PLAYERS-1:0] st, cn;
        for (int p = 0; p < PLAYERS; p++) begin
            st[p] = exp[p][BUTTONS+4] ^ ACTIVE_LOW;
            cn[p] = exp[p][BUTTONS+5] ^ ACTIVE_LOW;
        end
        check_game_joy(game_joystick1, expect_joy(exp[0]), $sformatf("set %0d joy1", idx));
        check_game_joy(game_joystick2, expect_joy(exp[1]), $sformatf("set %0d joy2", idx));
        check_game_joy(game_joystick3, expect_joy(exp[2]), $sformatf("set %0d joy3", idx));
        check_game_joy(game_joystick4, expect_joy(exp[3]), $sformatf("set %0d joy4", idx));
        check_bits(game_start, st, $sformatf("set %0d start", idx));
        check_bits(game_coin, cn, $sformatf("set %0d coin", idx));
    endtask

    // Random words or start and coin patterns on bits 5, 10, 11 and BUTTONS+4/5
    task automatic make_set(input bit patterns, input int idx, output joy_word_t db[2],
                            output joy_word_t usb[PLAYERS]);
        int v;
        for (int k = 0; k < PLAYERS; k++) begin
            v = idx + k;
            usb[k] = patterns ? '0 : joy_word_t'($urandom());
            if (patterns) usb[k][BUTTONS+4] = v[0];
            if (patterns) usb[k][BUTTONS+5] = v[1];
        end
        for (int k = 0; k < 2; k++) begin
            v = (k == 0) ? idx : 7 - idx;
            db[k] = patterns ? '0 : joy_word_t'($urandom());
            if (patterns) db[k][5] = v[0];
            if (patterns) db[k][10] = v[1];
            if (patterns) db[k][11] = v[2];
        end
    endtask

    // New source set every cycle and each checked two cycles later
    task automatic run_stream(input logic en1, input logic en2, input int count,
                              input bit patterns);
        wb_data_t rd;
        joy_word_t db[2];
        joy_word_t usb[PLAYERS];
        joy_word_t exp[PLAYERS];
        joy_word_t exp_q[$];
        wb_access(1'b1, 1'b1, {1'b0, en2, en1, 29'd0}, rd);
        for (int i = 0; i < count + 2; i++) begin
            if (i >= 2) begin
                for (int p = 0; p < PLAYERS; p++) exp[p] = exp_q.pop_front();
                compare_players(exp, i - 2);
            end
            if (i < count) begin
                make_set(patterns, i, db, usb);
                {joydb_1, joydb_2} = {db[0], db[1]};
                {usb_joy1, usb_joy2, usb_joy3, usb_joy4} = {usb[0], usb[1], usb[2], usb[3]};
                predict(en1, en2, db, usb, exp);
                for (int p = 0; p < PLAYERS; p++) exp_q.push_back(exp[p]);
            end
            @(negedge clk_sys);
        end
    endtask

    task automatic test_reset();
        wb_data_t lo, hi;
        check_bits({3'b0, wb_ack}, 4'b0, "ack after reset");
        check_game_joy(game_joystick1, expect_joy('0), "joy1 after reset");
        check_game_joy(game_joystick2, expect_joy('0), "joy2 after reset");
        check_game_joy(game_joystick3, expect_joy('0), "joy3 after reset");
        check_game_joy(game_joystick4, expect_joy('0), "joy4 after reset");
        check_bits(game_start, 4'hf, "start after reset");
        check_bits(game_coin, 4'hf, "coin after reset");
        wb_access(1'b0, 1'b0, '0, lo);
        wb_access(1'b0, 1'b1, '0, hi);
        check_status({hi, lo}, '0, "status read after reset");
    endtask

    task automatic test_wishbone();
        wb_data_t lo, hi, rd_lo, rd_hi;
        for (int i = 0; i < 4; i++) begin
            lo = wb_data_t'($urandom());
            hi = wb_data_t'($urandom());
            wb_access(1'b1, 1'b0, lo, rd_lo);
            wb_access(1'b1, 1'b1, hi, rd_hi);
            wb_access(1'b0, 1'b0, '0, rd_lo);
            wb_access(1'b0, 1'b1, '0, rd_hi);
            check_status({rd_hi, rd_lo}, {hi, lo}, "status read back");
            check_status(status, {hi, lo}, "status port");
        end
    endtask

    task automatic test_decode();
        wb_data_t r, rd;
        menumask_t mask;
        r = wb_data_t'($urandom());
        wb_access(1'b1, 1'b0, r, rd);
        check_offset(hoffset, r[27:24], "hoffset");
        check_offset(voffset, r[31:28], "voffset");
        check_bits({3'b0, hsize_enable}, {3'b0, r[19]}, "hsize_enable");
        check_bits(hsize_scale, r[23:20], "hsize_scale");
        for (int c = 0; c < 4; c++) begin
            core_mod     = 7'($urandom());
            core_mod[0]  = c[0];
            direct_video = c[1];
            @(negedge clk_sys);
            mask    = '0;
            mask[2] = ~r[19];
            mask[1] = ~c[0];
            mask[0] = c[1];
            check_menumask(status_menumask, mask, $sformatf("menumask case %0d", c));
        end
    endtask

    initial begin
        void'($urandom(78));
        {errors, checks, timeouts} = '0;
        {rst, wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = {1'b1, 36'd0};
        {core_mod, direct_video, joydb_1, joydb_2} = '0;
        {usb_joy1, usb_joy2, usb_joy3, usb_joy4} = '0;
        repeat (3) @(negedge clk_sys);
        rst = 1'b0;
        test_reset();
        test_wishbone();
        test_decode();
        run_stream(1'b0, 1'b0, 16, 1'b0);
        run_stream(1'b1, 1'b0, 16, 1'b0);
        run_stream(1'b1, 1'b1, 16, 1'b0);
        // Start and coin patterns in both modes
        run_stream(1'b1, 1'b1, 8, 1'b1);
        run_stream(1'b0, 1'b0, 8, 1'b1);
        finish_run();
    end

endmodule

`default_nettype wire

// File: tb.f
hdl/mister_pkg.sv
hdl/osd_status.sv
hdl/joy_source_mux.sv
hdl/game_input_map.sv
hdl/mister_ctrl_top.sv
tests/tb_mister_ctrl.sv

// File: run.sh
#!/bin/sh
# Compile and run the MiSTer control testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --timescale 1ns/1ps -f tb.f \
    --top-module tb_mister_ctrl -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "No result line found in the log"
    exit 1
fi
exit 0
